// File: data_mem_bridge.f
src/mem_bridge_pkg.sv
src/store_queue.sv
src/axi_write_engine.sv
src/axi_read_engine.sv
src/mem_req_ctrl.sv
src/data_mem_bridge.sv
test/data_mem_bridge_assertions.sv
test/data_mem_bridge_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the data_mem_bridge testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f data_mem_bridge.f \
  --top-module data_mem_bridge_tb -o sim_data_mem_bridge &&
./obj_dir/sim_data_mem_bridge | tee /dev/stderr | grep -qx "No errors" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// File: test/data_mem_bridge_tb.sv
`timescale 1ns/1ps

module data_mem_bridge_tb
  import mem_bridge_pkg::*;
;
  localparam int QUEUE_DEPTH = 10;

  logic clk, rst_n;
  logic mem_req_valid, mem_write, mem_req_ack, mem_rdata_valid, mem_rdata_ack;
  addr_t mem_addr, awaddr, araddr;
  data_t mem_wdata, mem_rdata, wdata, rdata;
  strb_t mem_wstrb, wstrb;
  logic [2:0] awsize, arsize;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;

  integer seed = 32'h9eb6_6181;
  int errors = 0;
  int ar_count = 0;
  int b_count = 0;
  int store_count = 0;
  int last_lat;
  data_t model [16];
  data_t slave_mem [16];

  // Slave state
  logic aw_hold = 0;
  logic aw_go, w_go, ar_go, have_aw, have_w, ar_pend;
  addr_t s_awaddr, s_araddr;
  data_t s_wdata;
  strb_t s_wstrb;

  data_mem_bridge #(.QUEUE_DEPTH(QUEUE_DEPTH)) DUT (
    .M_AXI_ACLK(clk), .M_AXI_ARESETN(rst_n),
    .mem_req_valid_i(mem_req_valid), .mem_addr_i(mem_addr), .mem_write_i(mem_write),
    .mem_wdata_i(mem_wdata), .mem_wstrb_i(mem_wstrb), .mem_req_ack_o(mem_req_ack),
    .mem_rdata_o(mem_rdata), .mem_rdata_valid_o(mem_rdata_valid),
    .mem_rdata_ack_i(mem_rdata_ack),
    .M_AXI_AWADDR(awaddr), .M_AXI_AWSIZE(awsize), .M_AXI_AWVALID(awvalid),
    .M_AXI_AWREADY(awready), .M_AXI_WDATA(wdata), .M_AXI_WSTRB(wstrb),
    .M_AXI_WVALID(wvalid), .M_AXI_WREADY(wready), .M_AXI_BVALID(bvalid),
    .M_AXI_BREADY(bready), .M_AXI_ARADDR(araddr), .M_AXI_ARSIZE(arsize),
    .M_AXI_ARVALID(arvalid), .M_AXI_ARREADY(arready), .M_AXI_RDATA(rdata),
    .M_AXI_RVALID(rvalid), .M_AXI_RREADY(rready)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic data_t merge(input data_t old, input data_t d, input strb_t s);
    data_t mask;
    mask = {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
    return (old & ~mask) | (d & mask);
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      errors++;
      $display("Fail %s: got %h expected %h", name, got, exp);
    end
  endtask

  ////////////////////
  // AXI slave model
  ////////////////////
  always @(negedge clk)
  begin
    if (!rst_n)
    begin
      {awready, wready, bvalid, arready, rvalid} = '0;
      {aw_go, w_go, ar_go, have_aw, have_w, ar_pend} = '0;
      rdata = '0;
    end
    else
    begin
      // Handshakes decided last half cycle took place at the posedge
      if (aw_go)
        have_aw = 1'b1;
      if (w_go)
        have_w = 1'b1;
      if (ar_go)
        ar_pend = 1'b1;
      if (bvalid)
      begin
        bvalid = 1'b0;
        b_count++;
      end
      rvalid = 1'b0;
      if (have_aw && have_w && ($random(seed) & 1))
      begin
        slave_mem[s_awaddr[5:2]] = merge(slave_mem[s_awaddr[5:2]], s_wdata, s_wstrb);
        {bvalid, have_aw, have_w} = 3'b100;
      end
      if (ar_pend && ($random(seed) & 1))
      begin
        rdata = slave_mem[s_araddr[5:2]];
        rvalid = 1'b1;
        ar_pend = 1'b0;
      end
      awready = !aw_hold && !have_aw && ($random(seed) & 1);
      wready  = !have_w && ($random(seed) & 1);
      arready = !ar_pend && !rvalid && ($random(seed) & 1);
      #1;
      aw_go = awvalid && awready;
      w_go  = wvalid && wready;
      ar_go = arvalid && arready;
      // Single beats of four bytes, responses always taken
      if (aw_go)
      begin
        s_awaddr = awaddr;
        check_val("M_AXI_AWSIZE", awsize, 3'd2);
      end
      if (w_go)
      begin
        s_wdata = wdata;
        s_wstrb = wstrb;
      end
      if (ar_go)
      begin
        s_araddr = araddr;
        ar_count++;
        check_val("M_AXI_ARSIZE", arsize, 3'd2);
      end
      if (bvalid)
        check_val("M_AXI_BREADY", bready, 1'b1);
      if (rvalid)
        check_val("M_AXI_RREADY", rready, 1'b1);
    end
  end

  // Waits up to limit cycles for the request to be taken
  task automatic wait_ack(input int limit, output bit ok);
    ok = 1'b0;
    for (int i = 0; i < limit; i++)
    begin
      #1;
      if (mem_req_ack)
      begin
        ok = 1'b1;
        return;
      end
      @(negedge clk);
    end
  endtask

  task automatic send_req(input logic wr, input int idx, input data_t d, input strb_t s);
    bit ok;
    data_t exp;
    @(negedge clk);
    mem_req_valid = 1'b1;
    mem_write = wr;
    mem_addr = addr_t'(idx) << 2;
    mem_wdata = d;
    mem_wstrb = s;
    wait_ack(2000, ok);
    if (!ok)
    begin
      errors++;
      $display("Timed out waiting for request acknowledge");
      mem_req_valid = 1'b0;
      return;
    end
    if (wr)
    begin
      model[idx] = merge(model[idx], d, s);
      store_count++;
      return;
    end
    exp = model[idx];
    last_lat = 0;
    do
    begin
      @(negedge clk);
      mem_req_valid = 1'b0;
      #1;
      last_lat++;
    end
    while (!mem_rdata_valid && last_lat < 2000);
    if (!mem_rdata_valid)
    begin
      errors++;
      $display("Timed out waiting for load data");
      return;
    end
    check_val("mem_rdata_o", mem_rdata, exp);
    mem_rdata_ack = 1'b1;
    @(negedge clk);
    mem_rdata_ack = 1'b0;
  endtask

  // Every accepted store ends in one write response
  task automatic wait_drain();
    int n;
    n = 0;
    @(negedge clk);
    mem_req_valid = 1'b0;
    #1;
    while (b_count < store_count && n < 2000)
    begin
      @(negedge clk);
      #1;
      n++;
    end
    if (n >= 2000)
    begin
      errors++;
      $display("Timed out waiting for all stores to reach memory");
    end
  endtask

  ////////////////////
  // Main sequence
  ////////////////////
  initial
  begin
    int ar_before, b_before;
    bit ok;
    {rst_n, mem_req_valid, mem_write, mem_rdata_ack} = '0;
    {mem_addr, mem_wdata, mem_wstrb} = '0;
    {awready, wready, bvalid, arready, rvalid} = '0;
    rdata = '0;
    for (int i = 0; i < 16; i++)
    begin
      slave_mem[i] = 32'h5a5a_0000 ^ (i * 32'h1111_1111);
      model[i] = slave_mem[i];
    end
    repeat (16) @(negedge clk);
    rst_n = 1'b1;

    // Random mix over 16 words
    for (int n = 0; n < 320; n++)
      send_req($random(seed) & 1, $random(seed) & 15, $random(seed),
               ($random(seed) & 1) ? 4'hf : strb_t'($random(seed)));
    wait_drain();

    // Full word store forwards to a following load
    aw_hold = 1'b1;
    ar_before = ar_count;
    send_req(1'b1, 5, $random(seed), 4'hf);
    send_req(1'b0, 5, '0, '0);
    check_val("load latency", last_lat, 1);
    check_val("AR handshakes", ar_count, ar_before);
    aw_hold = 1'b0;
    wait_drain();

    // Partial store makes the load go to memory
    ar_before = ar_count;
    send_req(1'b1, 6, $random(seed), 4'b0011);
    send_req(1'b0, 6, '0, '0);
    check_val("AR handshakes", ar_count, ar_before + 1);
    wait_drain();

    // Full queue holds off the next store
    aw_hold = 1'b1;
    for (int i = 0; i < QUEUE_DEPTH; i++)
      send_req(1'b1, i, $random(seed), 4'hf);
    @(negedge clk);
    mem_addr = 32'h2c;
    mem_wdata = $random(seed);
    mem_wstrb = 4'hf;
    for (int i = 0; i < 20; i++)
    begin
      #1;
      check_val("mem_req_ack_o", mem_req_ack, 1'b0);
      @(negedge clk);
    end
    b_before = b_count;
    aw_hold = 1'b0;
    wait_ack(2000, ok);
    if (ok)
    begin
      model[11] = mem_wdata;
      store_count++;
      check_val("write response seen", b_count > b_before, 1'b1);
    end
    else
    begin
      errors++;
      $display("Timed out waiting for a store to be taken after the queue freed");
    end
    wait_drain();

    for (int i = 0; i < 16; i++)
      check_val($sformatf("slave_mem[%0d]", i), slave_mem[i], model[i]);

    $display("Run complete with %0d errors", errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

// File: test/data_mem_bridge_assertions.sv
`timescale 1ns/1ps

module data_mem_bridge_assertions
  import mem_bridge_pkg::*;
(
  input logic  M_AXI_ACLK,
  input logic  M_AXI_ARESETN,
  input logic  M_AXI_AWVALID,
  input logic  M_AXI_AWREADY,
  input addr_t M_AXI_AWADDR,
  input logic  M_AXI_ARVALID,
  input logic  M_AXI_ARREADY,
  input logic  mem_rdata_valid_o,
  input logic  mem_rdata_ack_i,
  input data_t mem_rdata_o
);

  // Write address held until accepted
  aw_stable: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
    M_AXI_AWVALID && !M_AXI_AWREADY |=> M_AXI_AWVALID && $stable(M_AXI_AWADDR))
    else $error("AWVALID or AWADDR changed before AWREADY");

  ar_stable: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
    M_AXI_ARVALID && !M_AXI_ARREADY |=> M_AXI_ARVALID)
    else $error("ARVALID dropped before ARREADY");

  // Load response held until the memory stage takes it
  rdata_stable: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
    mem_rdata_valid_o && !mem_rdata_ack_i |=> mem_rdata_valid_o && $stable(mem_rdata_o))
    else $error("Load response changed before mem_rdata_ack_i");

endmodule

bind data_mem_bridge data_mem_bridge_assertions u_assertions (.*);

// File: src/data_mem_bridge.sv
`timescale 1ns/1ps

module data_mem_bridge
  import mem_bridge_pkg::*;
#(
  parameter int QUEUE_DEPTH = 10
)
(
  input  logic       M_AXI_ACLK,
  input  logic       M_AXI_ARESETN,
  // Memory stage
  input  logic       mem_req_valid_i,
  input  addr_t      mem_addr_i,
  input  logic       mem_write_i,
  input  data_t      mem_wdata_i,
  input  strb_t      mem_wstrb_i,
  output logic       mem_req_ack_o,
  output data_t      mem_rdata_o,
  output logic       mem_rdata_valid_o,
  input  logic       mem_rdata_ack_i,
  // AXI write channels
  output addr_t      M_AXI_AWADDR,
  output logic [2:0] M_AXI_AWSIZE,
  output logic       M_AXI_AWVALID,
  input  logic       M_AXI_AWREADY,
  output data_t      M_AXI_WDATA,
  output strb_t      M_AXI_WSTRB,
  output logic       M_AXI_WVALID,
  input  logic       M_AXI_WREADY,
  input  logic       M_AXI_BVALID,
  output logic       M_AXI_BREADY,
  // AXI read channels
  output addr_t      M_AXI_ARADDR,
  output logic [2:0] M_AXI_ARSIZE,
  output logic       M_AXI_ARVALID,
  input  logic       M_AXI_ARREADY,
  input  data_t      M_AXI_RDATA,
  input  logic       M_AXI_RVALID,
  output logic       M_AXI_RREADY
);

  logic  q_full, q_empty, fwd_hit, push, pop, write_busy, rd_start, rd_done;
  addr_t head_addr, push_addr, lookup_addr, rd_addr;
  data_t head_data, fwd_data, push_data, rd_data;
  strb_t head_strb, push_strb;

  assign M_AXI_AWSIZE = AXI_SIZE_WORD;
  assign M_AXI_ARSIZE = AXI_SIZE_WORD;
  assign M_AXI_BREADY = 1'b1;
  assign M_AXI_RREADY = 1'b1;

  store_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_store_queue (
    .M_AXI_ACLK, .M_AXI_ARESETN,
    .push_i(push), .push_addr_i(push_addr), .push_data_i(push_data),
    .push_strb_i(push_strb), .pop_i(pop), .lookup_addr_i(lookup_addr),
    .full_o(q_full), .empty_o(q_empty), .head_addr_o(head_addr),
    .head_data_o(head_data), .head_strb_o(head_strb),
    .fwd_hit_o(fwd_hit), .fwd_data_o(fwd_data)
  );

  axi_write_engine u_write_engine (
    .M_AXI_ACLK, .M_AXI_ARESETN,
    .queue_empty_i(q_empty), .head_addr_i(head_addr),
    .head_data_i(head_data), .head_strb_i(head_strb),
    .M_AXI_AWREADY, .M_AXI_WREADY, .M_AXI_BVALID,
    .pop_o(pop), .write_busy_o(write_busy),
    .M_AXI_AWADDR, .M_AXI_AWVALID, .M_AXI_WDATA, .M_AXI_WSTRB, .M_AXI_WVALID
  );

  axi_read_engine u_read_engine (
    .M_AXI_ACLK, .M_AXI_ARESETN,
    .rd_start_i(rd_start), .rd_addr_i(rd_addr),
    .M_AXI_ARREADY, .M_AXI_RDATA, .M_AXI_RVALID,
    .M_AXI_ARADDR, .M_AXI_ARVALID,
    .rd_done_o(rd_done), .rd_data_o(rd_data)
  );

  mem_req_ctrl #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_req_ctrl (
    .M_AXI_ACLK, .M_AXI_ARESETN,
    .mem_req_valid_i, .mem_addr_i, .mem_write_i, .mem_wdata_i, .mem_wstrb_i,
    .mem_rdata_ack_i,
    .queue_full_i(q_full), .queue_empty_i(q_empty),
    .fwd_hit_i(fwd_hit), .fwd_data_i(fwd_data), .write_busy_i(write_busy),
    .rd_done_i(rd_done), .rd_data_i(rd_data),
    .mem_req_ack_o, .mem_rdata_o, .mem_rdata_valid_o,
    .push_o(push), .push_addr_o(push_addr), .push_data_o(push_data),
    .push_strb_o(push_strb), .lookup_addr_o(lookup_addr),
    .rd_start_o(rd_start), .rd_addr_o(rd_addr)
  );

endmodule

// File: src/mem_req_ctrl.sv
`timescale 1ns/1ps

module mem_req_ctrl
  import mem_bridge_pkg::*;
#(
  parameter int QUEUE_DEPTH = 10
)
(
  input  logic  M_AXI_ACLK,
  input  logic  M_AXI_ARESETN,
  input  logic  mem_req_valid_i,
  input  addr_t mem_addr_i,
  input  logic  mem_write_i,
  input  data_t mem_wdata_i,
  input  strb_t mem_wstrb_i,
  input  logic  mem_rdata_ack_i,
  input  logic  queue_full_i,
  input  logic  queue_empty_i,
  input  logic  fwd_hit_i,
  input  data_t fwd_data_i,
  input  logic  write_busy_i,
  input  logic  rd_done_i,
  input  data_t rd_data_i,
  output logic  mem_req_ack_o,
  output data_t mem_rdata_o,
  output logic  mem_rdata_valid_o,
  output logic  push_o,
  output addr_t push_addr_o,
  output data_t push_data_o,
  output strb_t push_strb_o,
  output addr_t lookup_addr_o,
  output logic  rd_start_o,
  output addr_t rd_addr_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_DRAIN,
    ST_READ,
    ST_RESP
  } ctrl_state_t;

  ctrl_state_t state_q;
  addr_t       load_addr_q;
  data_t       rdata_q;
  logic        load_ack;

  // Forwarding and back-pressure need room for two stores
  if (QUEUE_DEPTH < 2)
  begin : g_depth_check
    $error("QUEUE_DEPTH must be at least 2");
  end

  // Loads always fit, stores need a free entry
  assign mem_req_ack_o = (state_q == ST_IDLE) && mem_req_valid_i
                         && (!mem_write_i || !queue_full_i);
  assign load_ack      = mem_req_ack_o && !mem_write_i;

  assign push_o        = mem_req_ack_o && mem_write_i;
  assign push_addr_o   = mem_addr_i;
  assign push_data_o   = mem_wdata_i;
  assign push_strb_o   = mem_wstrb_i;
  assign lookup_addr_o = mem_addr_i;

  // Miss read goes out only once all older stores are in memory
  assign rd_start_o = (state_q == ST_DRAIN) && queue_empty_i && !write_busy_i;
  assign rd_addr_o  = load_addr_q;

  assign mem_rdata_valid_o = (state_q == ST_RESP);
  assign mem_rdata_o       = rdata_q;

  always_ff @(posedge M_AXI_ACLK)
  begin
    if (load_ack && !fwd_hit_i)
      load_addr_q <= mem_addr_i;
    if (load_ack && fwd_hit_i)
      rdata_q <= fwd_data_i;
    else if (state_q == ST_READ && rd_done_i)
      rdata_q <= rd_data_i;
  end

  ////////////////////
  // Request FSM
  ////////////////////
  always_ff @(posedge M_AXI_ACLK)
  begin
    if (!M_AXI_ARESETN)
      state_q <= ST_IDLE;
    else
    begin
      case (state_q)
        ST_IDLE:
        begin
          if (load_ack)
            state_q <= fwd_hit_i ? ST_RESP : ST_DRAIN;
        end
        ST_DRAIN: if (rd_start_o) state_q <= ST_READ;
        ST_READ:  if (rd_done_i) state_q <= ST_RESP;
        ST_RESP:  if (mem_rdata_ack_i) state_q <= ST_IDLE;
        default:  state_q <= ST_IDLE;
      endcase
    end
  end

endmodule

// File: src/axi_read_engine.sv
`timescale 1ns/1ps

module axi_read_engine
  import mem_bridge_pkg::*;
(
  input  logic  M_AXI_ACLK,
  input  logic  M_AXI_ARESETN,
  input  logic  rd_start_i,
  input  addr_t rd_addr_i,
  input  logic  M_AXI_ARREADY,
  input  data_t M_AXI_RDATA,
  input  logic  M_AXI_RVALID,
  output addr_t M_AXI_ARADDR,
  output logic  M_AXI_ARVALID,
  output logic  rd_done_o,
  output data_t rd_data_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ADDR,
    ST_DATA
  } rd_state_t;

  rd_state_t state_q;
  addr_t     araddr_q;
  data_t     rdata_q;
  logic      done_q;

  assign M_AXI_ARADDR  = araddr_q;
  assign M_AXI_ARVALID = (state_q == ST_ADDR);
  assign rd_done_o     = done_q;
  assign rd_data_o     = rdata_q;

  // Payload captures
  always_ff @(posedge M_AXI_ACLK)
  begin
    if (state_q == ST_IDLE && rd_start_i)
      araddr_q <= rd_addr_i;
    if (state_q == ST_DATA && M_AXI_RVALID)
      rdata_q <= M_AXI_RDATA;
  end

  ////////////////////
  // Read FSM
  ////////////////////
  always_ff @(posedge M_AXI_ACLK)
  begin
    if (!M_AXI_ARESETN)
    begin
      state_q <= ST_IDLE;
      done_q  <= 1'b0;
    end
    else
    begin
      done_q <= 1'b0;
      case (state_q)
        ST_IDLE: if (rd_start_i) state_q <= ST_ADDR;
        ST_ADDR: if (M_AXI_ARREADY) state_q <= ST_DATA;
        ST_DATA:
        begin
          // Single beat, RREADY always high
          if (M_AXI_RVALID)
          begin
            done_q  <= 1'b1;
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

endmodule

// File: src/axi_write_engine.sv
`timescale 1ns/1ps

module axi_write_engine
  import mem_bridge_pkg::*;
(
  input  logic  M_AXI_ACLK,
  input  logic  M_AXI_ARESETN,
  input  logic  queue_empty_i,
  input  addr_t head_addr_i,
  input  data_t head_data_i,
  input  strb_t head_strb_i,
  input  logic  M_AXI_AWREADY,
  input  logic  M_AXI_WREADY,
  input  logic  M_AXI_BVALID,
  output logic  pop_o,
  output logic  write_busy_o,
  output addr_t M_AXI_AWADDR,
  output logic  M_AXI_AWVALID,
  output data_t M_AXI_WDATA,
  output strb_t M_AXI_WSTRB,
  output logic  M_AXI_WVALID
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ADDR_DATA,
    ST_RESP
  } wr_state_t;

  wr_state_t state_q;
  logic      aw_done_q;
  logic      w_done_q;
  logic      aw_fire;
  logic      w_fire;

  // Head entry stays put until popped
  assign M_AXI_AWADDR = head_addr_i;
  assign M_AXI_WDATA  = head_data_i;
  assign M_AXI_WSTRB  = head_strb_i;

  assign M_AXI_AWVALID = (state_q == ST_ADDR_DATA) && !aw_done_q;
  assign M_AXI_WVALID  = (state_q == ST_ADDR_DATA) && !w_done_q;

  assign aw_fire = M_AXI_AWVALID && M_AXI_AWREADY;
  assign w_fire  = M_AXI_WVALID && M_AXI_WREADY;

  // Entry leaves only once memory has taken it
  assign pop_o        = (state_q == ST_RESP) && M_AXI_BVALID;
  assign write_busy_o = (state_q != ST_IDLE);

  ////////////////////
  // Write FSM
  ////////////////////
  always_ff @(posedge M_AXI_ACLK)
  begin
    if (!M_AXI_ARESETN)
    begin
      state_q   <= ST_IDLE;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end
    else
    begin
      case (state_q)
        ST_IDLE:
        begin
          aw_done_q <= 1'b0;
          w_done_q  <= 1'b0;
          if (!queue_empty_i)
            state_q <= ST_ADDR_DATA;
        end
        ST_ADDR_DATA:
        begin
          if (aw_fire)
            aw_done_q <= 1'b1;
          if (w_fire)
            w_done_q <= 1'b1;
          if ((aw_done_q || aw_fire) && (w_done_q || w_fire))
            state_q <= ST_RESP;
        end
        ST_RESP:
        begin
          if (M_AXI_BVALID)
            state_q <= ST_IDLE;
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

endmodule

// File: src/store_queue.sv
`timescale 1ns/1ps

module store_queue
  import mem_bridge_pkg::*;
#(
  parameter int QUEUE_DEPTH = 10
)
(
  input  logic      M_AXI_ACLK,
  input  logic      M_AXI_ARESETN,
  input  logic      push_i,
  input  addr_t     push_addr_i,
  input  data_t     push_data_i,
  input  strb_t     push_strb_i,
  input  logic      pop_i,
  input  addr_t     lookup_addr_i,
  output logic      full_o,
  output logic      empty_o,
  output addr_t     head_addr_o,
  output data_t     head_data_o,
  output strb_t     head_strb_o,
  output logic      fwd_hit_o,
  output data_t     fwd_data_o
);

  localparam int PTR_W = $clog2(QUEUE_DEPTH);
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  typedef logic [PTR_W-1:0] ptr_t;

  addr_t                  entry_addr_q [QUEUE_DEPTH];
  data_t                  entry_data_q [QUEUE_DEPTH];
  strb_t                  entry_strb_q [QUEUE_DEPTH];
  logic [QUEUE_DEPTH-1:0] fwd_valid_q;

  ptr_t             wr_ptr_q;
  ptr_t             rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  logic      push_en;
  logic      pop_en;
  word_tag_t push_tag;
  word_tag_t lookup_tag;

  // Circular pointer step, wraps at any depth
  function automatic ptr_t next_ptr(input ptr_t ptr);
    if (ptr == ptr_t'(QUEUE_DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign full_o  = (count_q == CNT_W'(QUEUE_DEPTH));
  assign empty_o = (count_q == '0);
  assign push_en = push_i && !full_o;
  assign pop_en  = pop_i && !empty_o;

  assign push_tag   = push_addr_i[ADDR_W-1:2];
  assign lookup_tag = lookup_addr_i[ADDR_W-1:2];

  assign head_addr_o = entry_addr_q[rd_ptr_q];
  assign head_data_o = entry_data_q[rd_ptr_q];
  assign head_strb_o = entry_strb_q[rd_ptr_q];

  ////////////////////
  // Pointers and occupancy
  ////////////////////
  always_ff @(posedge M_AXI_ACLK)
  begin
    if (!M_AXI_ARESETN)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push_en)
        wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop_en)
        rd_ptr_q <= next_ptr(rd_ptr_q);
      if (push_en && !pop_en)
        count_q <= count_q + 1'b1;
      else if (pop_en && !push_en)
        count_q <= count_q - 1'b1;
    end
  end

  // Entry storage
  always_ff @(posedge M_AXI_ACLK)
  begin
    if (push_en)
    begin
      entry_addr_q[wr_ptr_q] <= push_addr_i;
      entry_data_q[wr_ptr_q] <= push_data_i;
      entry_strb_q[wr_ptr_q] <= push_strb_i;
    end
  end

  ////////////////////
  // Forwarding valid bits
  ////////////////////
  always_ff @(posedge M_AXI_ACLK)
  begin
    if (!M_AXI_ARESETN)
      fwd_valid_q <= '0;
    else
    begin
      // A newer store to the same word hides older ones
      for (int i = 0; i < QUEUE_DEPTH; i++)
      begin
        if (push_en && entry_addr_q[i][ADDR_W-1:2] == push_tag)
          fwd_valid_q[i] <= 1'b0;
      end
      if (pop_en)
        fwd_valid_q[rd_ptr_q] <= 1'b0;
      // Only full word stores may forward
      if (push_en)
        fwd_valid_q[wr_ptr_q] <= &push_strb_i;
    end
  end

  // At most one valid entry matches a word
  always_comb
  begin
    fwd_hit_o  = 1'b0;
    fwd_data_o = '0;
    for (int i = 0; i < QUEUE_DEPTH; i++)
    begin
      if (fwd_valid_q[i] && entry_addr_q[i][ADDR_W-1:2] == lookup_tag)
      begin
        fwd_hit_o  = 1'b1;
        fwd_data_o = fwd_data_o | entry_data_q[i];
      end
    end
  end

endmodule

// File: src/mem_bridge_pkg.sv
package mem_bridge_pkg;

  ////////////////////
  // Bus widths
  ////////////////////
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  ////////////////////
  // Vector types
  ////////////////////
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;

  // Word address, byte offset bits removed
  typedef logic [ADDR_W-3:0] word_tag_t;

  // AxSIZE code for a four byte beat
  localparam logic [2:0] AXI_SIZE_WORD = 3'd2;

endpackage
